// File: design/fprint_defs.svh
`ifndef FPRINT_DEFS_SVH
`define FPRINT_DEFS_SVH

// width of one processor write word
`define FP_DATA_W 32

// crc-32 generator polynomial
// bits are folded msb first and never reflected
`define FP_CRC_POLY 32'h04C11DB7

// every block starts its crc from all ones
`define FP_CRC_SEED 32'hFFFF_FFFF

// words per full block
// any value from 2 up to 256 is fine for the counter below
`define FP_BLOCK_WORDS 8

// block counter width
// must hold FP_BLOCK_WORDS minus one
`define FP_COUNT_W 8

`endif

// File: design/fprint_pkg.sv
`include "fprint_defs.svh"

package fprint_pkg;

	// one word from the processor write bus
	typedef logic [`FP_DATA_W-1:0] word_t;

	// running crc and published fingerprint share this type
	typedef logic [31:0] crc_t;

	// number of words absorbed in the open block
	typedef logic [`FP_COUNT_W-1:0] count_t;

	// fingerprint controller states
	// st_init        waiting for the first word of a block, or paused
	// st_first_write the first word of a block was just taken
	// st_write       a later word of the block was just taken
	// st_idle        block open with no write on the last cycle
	// st_block_done  a full block was just published
	// st_task_done   a partial block was just published
	typedef enum logic [2:0] {
		st_init        = 3'd0,
		st_first_write = 3'd1,
		st_write       = 3'd2,
		st_idle        = 3'd3,
		st_block_done  = 3'd4,
		st_task_done   = 3'd5
	} fp_state_t;

endpackage

// File: design/fprint_ctrl_if.sv
`timescale 1ns/1ps

interface fprint_ctrl_if import fprint_pkg::*; ();

	// absorb the word on the write bus this cycle
	logic en_fcs;
	// 1 folds into the running crc
	// 0 folds into the seed and opens a new block
	logic sel;
	// close the open block and publish its crc
	logic crc_ready;
	// words absorbed so far in the open block
	count_t count;
	// the word taken this cycle is the last of its block
	logic count_max;

	// controller side
	// drives the strobes and watches the block fill level
	modport fsm (
		output en_fcs,
		output sel,
		output crc_ready,
		input  count,
		input  count_max
	);

	// word counter side
	modport counter (
		input  en_fcs,
		input  crc_ready,
		output count,
		output count_max
	);

	// crc accumulator side only listens
	modport crc (
		input en_fcs,
		input sel,
		input crc_ready
	);

endinterface

// File: design/fprint_ctrl_fsm.sv
`timescale 1ns/1ps

module fprint_ctrl_fsm import fprint_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   wrte,
	input  logic   en_fprint,
	input  logic   pause,
	input  logic   resume,
	fprint_ctrl_if.fsm ctrl,
	output logic   busy
);

	fp_state_t state_q;
	fp_state_t state_d;

	// set by pause and held until a resume arrives
	logic paused_q;

	// controller is free to act this cycle
	logic active;
	// a write is taken into the fingerprint
	logic accept;
	// words are pending in the open block
	logic count_nz;
	// block already holds at least one word
	logic cont_block;
	// en_fprint dropped with a partial block pending
	logic close_part;

	// a pause level over an edge always wins
	// a pending pause also blocks writes until resume clears it
	assign active = !pause && !paused_q;

	assign accept = active && wrte && en_fprint;

	assign count_nz = (ctrl.count != '0);

	// these states only follow a word of a still open block
	assign cont_block = (state_q == st_first_write) ||
		(state_q == st_write) ||
		(state_q == st_idle);

	// partial close never sees an accepted word
	// since en_fprint is low in that cycle
	assign close_part = active && !en_fprint && count_nz;

	// strobes to the counter and the crc unit
	assign ctrl.en_fcs = accept;

	// the first word after init or after any close starts from the seed
	assign ctrl.sel = cont_block;

	// count_max is already qualified by en_fcs in the counter
	assign ctrl.crc_ready = ctrl.count_max || close_part;

	// busy covers pending words and the write states themselves
	assign busy = count_nz ||
		(state_q == st_first_write) ||
		(state_q == st_write);

	// next state
	always_comb begin
		state_d = state_q;
		if (pause) begin
			// suspend without touching count or crc
			state_d = st_init;
		end else if (paused_q) begin
			// back into the open block, or a clean start
			if (resume && count_nz) begin
				state_d = st_idle;
			end else begin
				state_d = st_init;
			end
		end else if (ctrl.count_max) begin
			state_d = st_block_done;
		end else if (close_part) begin
			state_d = st_task_done;
		end else if (accept) begin
			// a continued block moves on to st_write
			if (cont_block) begin
				state_d = st_write;
			end else begin
				state_d = st_first_write;
			end
		end else begin
			case (state_q)
				st_first_write,
				st_write: begin
					// gap between writes with the block still open
					state_d = st_idle;
				end
				st_block_done,
				st_task_done: begin
					// nothing pending after a close
					state_d = st_init;
				end
				default: begin
					state_d = state_q;
				end
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= st_init;
		end else begin
			state_q <= state_d;
		end
	end

	// pause flag
	// resume only clears it once pause itself is low
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			paused_q <= 1'b0;
		end else if (pause) begin
			paused_q <= 1'b1;
		end else if (resume) begin
			paused_q <= 1'b0;
		end
	end

endmodule

// File: design/block_counter.sv
`timescale 1ns/1ps
`include "fprint_defs.svh"

module block_counter import fprint_pkg::*; (
	input  logic clk,
	input  logic rst,
	fprint_ctrl_if.counter ctrl
);

	// index of the last word in a full block
	localparam count_t LAST_IDX = count_t'(`FP_BLOCK_WORDS - 1);

	count_t count_q;

	// words already taken in this block
	assign ctrl.count = count_q;

	// last word flag
	// only raised while a word is really being absorbed
	assign ctrl.count_max = ctrl.en_fcs && (count_q == LAST_IDX);

	// close has priority
	// the word that fills the block is counted by the wrap itself
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count_q <= '0;
		end else if (ctrl.crc_ready) begin
			count_q <= '0;
		end else if (ctrl.en_fcs) begin
			count_q <= count_q + count_t'(1);
		end
	end

endmodule

// File: design/crc_block_unit.sv
`timescale 1ns/1ps
`include "fprint_defs.svh"

module crc_block_unit import fprint_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  word_t wr_data,
	fprint_ctrl_if.crc ctrl,
	output logic  fp_valid,
	output crc_t  fingerprint
);

	localparam crc_t CRC_SEED = `FP_CRC_SEED;
	localparam crc_t CRC_POLY = `FP_CRC_POLY;

	// running crc of the open block
	crc_t crc_q;
	// starting point for this cycle's word
	crc_t crc_base;
	// running crc after this cycle
	crc_t crc_next;

	// fold one whole word into a crc
	// one shift and conditional xor per data bit, msb first
	function automatic crc_t crc_fold(input crc_t crc_in, input word_t data);
		crc_t c;
		logic fb;
		c = crc_in;
		for (int i = `FP_DATA_W - 1; i >= 0; i--) begin
			fb = c[31] ^ data[i];
			c = {c[30:0], 1'b0};
			if (fb) begin
				c = c ^ CRC_POLY;
			end
		end
		return c;
	endfunction

	// sel low restarts from the seed on the first word of a block
	assign crc_base = ctrl.sel ? crc_q : CRC_SEED;

	// no word this cycle leaves the running value as it is
	// a partial close then publishes it unchanged
	assign crc_next = ctrl.en_fcs ? crc_fold(crc_base, wr_data) : crc_q;

	// running crc
	// back to the seed on every close
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			crc_q <= CRC_SEED;
		end else if (ctrl.crc_ready) begin
			crc_q <= CRC_SEED;
		end else if (ctrl.en_fcs) begin
			crc_q <= crc_next;
		end
	end

	// one cycle strobe after the closing edge
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fp_valid <= 1'b0;
		end else begin
			fp_valid <= ctrl.crc_ready;
		end
	end

	// published value stays put until the next close
	always_ff @(posedge clk) begin
		if (ctrl.crc_ready) begin
			fingerprint <= crc_next;
		end
	end

endmodule

// File: design/fprint_top.sv
`timescale 1ns/1ps

module fprint_top import fprint_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	// processor write strobe and data
	input  logic  wrte,
	input  word_t wr_data,
	// fingerprinting enable level
	input  logic  en_fprint,
	// suspend and return to the open block
	input  logic  pause,
	input  logic  resume,
	// one cycle pulse with a new fingerprint
	output logic  fp_valid,
	output crc_t  fingerprint,
	// words pending or a write in progress
	output logic  busy
);

	// control strobes shared by the three blocks
	fprint_ctrl_if ctrl_if ();

	// decides acceptance, seed restart and block close
	fprint_ctrl_fsm i_fsm (
		.clk       (clk),
		.rst       (rst),
		.wrte      (wrte),
		.en_fprint (en_fprint),
		.pause     (pause),
		.resume    (resume),
		.ctrl      (ctrl_if.fsm),
		.busy      (busy)
	);

	// fill level of the open block
	block_counter i_counter (
		.clk  (clk),
		.rst  (rst),
		.ctrl (ctrl_if.counter)
	);

	// crc accumulator and fingerprint register
	crc_block_unit i_crc (
		.clk         (clk),
		.rst         (rst),
		.wr_data     (wr_data),
		.ctrl        (ctrl_if.crc),
		.fp_valid    (fp_valid),
		.fingerprint (fingerprint)
	);

endmodule

// File: tests/fprint_assertions.sv
`timescale 1ns/1ps

module fprint_assertions import fprint_pkg::*; (
	input logic      clk,
	input logic      rst,
	input logic      wrte,
	input logic      en_fcs,
	input logic      crc_ready,
	input count_t    count,
	input fp_state_t state
);

	// failed assertions so far
	int fail_count = 0;

	// a word is only counted on a processor write
	a_count_needs_wrte: assert property (@(posedge clk) disable iff (rst)
		(!wrte && !crc_ready) |=> $stable(count))
		else begin
			$error("block count moved without wrte");
			fail_count++;
		end

	// every absorbed word outside a close adds one to the block count
	a_fcs_counts: assert property (@(posedge clk) disable iff (rst)
		(en_fcs && !crc_ready) |=> (count == $past(count) + count_t'(1)))
		else begin
			$error("block count did not follow en_fcs");
			fail_count++;
		end

	// a close lasts a single cycle
	a_ready_single: assert property (@(posedge clk) disable iff (rst) crc_ready |=> !crc_ready)
		else begin
			$error("crc_ready high on two consecutive cycles");
			fail_count++;
		end

	// a close empties the block and lands in a done state
	a_close_clears: assert property (@(posedge clk) disable iff (rst)
		crc_ready |=> ((count == '0) && (state inside {st_block_done, st_task_done})))
		else begin
			$error("close did not clear the count or reach a done state");
			fail_count++;
		end

endmodule

// File: tests/tb_fprint.sv
`timescale 1ns/1ps
`include "fprint_defs.svh"

module tb_fprint import fprint_pkg::*; ();

	// reset, the six directed and random tests, and a few drain cycles
	localparam int STIM_CYCLES = 16 + 160 + 16 + 12 + 17 + 10 + 2002 + 20;
	localparam int CYCLE_LIMIT = 4 * STIM_CYCLES;
	localparam crc_t SEED = `FP_CRC_SEED;
	localparam crc_t POLY = `FP_CRC_POLY;

	logic  clk = 1'b0;
	logic  rst;
	logic  wrte;
	logic  en_fprint;
	logic  pause;
	logic  resume;
	word_t wr_data;
	logic  fp_valid;
	crc_t  fingerprint;
	logic  busy;

	// reference model state
	int    m_count;
	crc_t  m_crc;
	logic  m_paused;
	logic  m_active;
	logic  m_accept;
	crc_t  expected_q[$];

	int          n_fp = 0;
	int          fp_base = 0;
	int          cycle_count = 0;
	string       test_name = "reset";
	logic [31:0] rand_state = 32'h008071fe;

	fprint_top i_dut (
		.clk(clk), .rst(rst), .wrte(wrte), .wr_data(wr_data), .en_fprint(en_fprint),
		.pause(pause), .resume(resume), .fp_valid(fp_valid), .fingerprint(fingerprint),
		.busy(busy)
	);

	bind fprint_ctrl_fsm fprint_assertions i_assert (
		.clk(clk), .rst(rst), .wrte(wrte), .en_fcs(ctrl.en_fcs),
		.crc_ready(ctrl.crc_ready), .count(ctrl.count), .state(state_q)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// crc-32 msb first
	// the whole word goes into the register, then one shift per bit
	function automatic crc_t crc_word(input crc_t crc, input word_t data);
		crc_t r;
		r = crc ^ data;
		repeat (32) begin
			r = r[31] ? ((r << 1) ^ POLY) : (r << 1);
		end
		return r;
	endfunction

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	// inputs change 2 ns after the rising edge
	task automatic drive(input logic w, input word_t d, input logic en, input logic p,
		input logic r);
		wrte = w;
		wr_data = d;
		en_fprint = en;
		pause = p;
		resume = r;
		@(posedge clk);
		#2;
	endtask

	// n writes with en_fprint high and 0 to gap_max idle cycles before each
	task automatic write_words(input int n, input int gap_max);
		int gap;
		for (int i = 0; i < n; i++) begin
			gap = int'(next_rand() % (gap_max + 1));
			repeat (gap) drive(1'b0, next_rand(), 1'b1, 1'b0, 1'b0);
			drive(1'b1, next_rand(), 1'b1, 1'b0, 1'b0);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		fp_base = n_fp;
	endtask

	// idle until every expected fingerprint has been seen, then count them
	task automatic end_test(input int n);
		while (expected_q.size() != 0) drive(1'b0, '0, en_fprint, 1'b0, 1'b0);
		check_value({test_name, " fingerprints"}, 32'(n), 32'(n_fp - fp_base));
	endtask

	// model sees the same inputs at the same edge as the DUT
	always @(posedge clk or posedge rst) begin
		if (rst) begin
			m_count = 0;
			m_crc = SEED;
			m_paused = 1'b0;
		end else begin
			m_active = !pause && !m_paused;
			m_accept = m_active && wrte && en_fprint;
			if (m_accept) begin
				m_crc = crc_word(m_crc, wr_data);
				if (m_count == `FP_BLOCK_WORDS - 1) begin
					expected_q.push_back(m_crc);
					m_crc = SEED;
					m_count = 0;
				end else begin
					m_count++;
				end
			end else if (m_active && !en_fprint && m_count != 0) begin
				// partial block closes when fingerprinting is switched off
				expected_q.push_back(m_crc);
				m_crc = SEED;
				m_count = 0;
			end
			if (pause) begin
				m_paused = 1'b1;
			end else if (resume) begin
				m_paused = 1'b0;
			end
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			check_value({test_name, " busy"}, 32'(m_count != 0), 32'(busy));
			if (fp_valid) begin
				if (expected_q.size() == 0) begin
					fail_run("fp_valid pulsed while the model expected no fingerprint");
				end else begin
					check_value({test_name, " fingerprint"}, expected_q.pop_front(), fingerprint);
					n_fp++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			fail_run("timeout, the tests did not finish within the cycle limit");
		end
	end

	initial begin
		logic [31:0] r;
		rst = 1'b1;
		wrte = 1'b0;
		wr_data = '0;
		en_fprint = 1'b0;
		pause = 1'b0;
		resume = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;

		start_test("full_blocks");
		write_words(40, 3);
		end_test(5);

		// second block must restart from the seed
		start_test("back_to_back");
		write_words(16, 0);
		end_test(2);

		// close after 3 words, then a second drop with nothing pending
		start_test("partial_close");
		write_words(3, 1);
		drive(1'b0, '0, 1'b0, 1'b0, 1'b0);
		drive(1'b0, '0, 1'b0, 1'b0, 1'b0);
		drive(1'b0, '0, 1'b1, 1'b0, 1'b0);
		drive(1'b0, '0, 1'b0, 1'b0, 1'b0);
		end_test(1);

		// writes under pause and before resume are ignored
		start_test("pause_resume");
		write_words(3, 0);
		drive(1'b1, next_rand(), 1'b1, 1'b1, 1'b0);
		drive(1'b1, next_rand(), 1'b1, 1'b1, 1'b0);
		drive(1'b1, next_rand(), 1'b1, 1'b0, 1'b0);
		drive(1'b1, next_rand(), 1'b1, 1'b0, 1'b1);
		write_words(5, 1);
		end_test(1);

		start_test("fprint_off");
		repeat (10) drive(1'b1, next_rand(), 1'b0, 1'b0, 1'b0);
		end_test(0);

		start_test("random_stress");
		repeat (2000) begin
			r = next_rand();
			drive(r[0] | r[1], next_rand(), r[4:2] != 3'd0, r[9:6] == 4'd0, r[13:10] < 4'd3);
		end
		// leave any pause and flush a partial block
		drive(1'b0, '0, 1'b1, 1'b0, 1'b1);
		drive(1'b0, '0, 1'b0, 1'b0, 1'b0);
		// the last close pulses fp_valid on the following edge
		repeat (2) drive(1'b0, '0, 1'b0, 1'b0, 1'b0);
		check_value("random_stress queue", 32'd0, 32'(expected_q.size()));

		if (i_dut.i_fsm.i_assert.fail_count != 0) begin
			$display("controller assertions failed %0d times", i_dut.i_fsm.i_assert.fail_count);
			$display("SIMULATION FAILED");
			$fatal(1);
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

// File: list.f
+incdir+design
design/fprint_pkg.sv
design/fprint_ctrl_if.sv
design/fprint_ctrl_fsm.sv
design/block_counter.sv
design/crc_block_unit.sv
design/fprint_top.sv
tests/fprint_assertions.sv
tests/tb_fprint.sv

// File: Makefile
TOP = tb_fprint

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir
